//--- flist.f
+incdir+design
design/uart_pkg.sv
design/uart_ctrl.sv
design/uart_tx_shift.sv
design/uart_rx_shift.sv
design/uart_link.sv
tests/uart_tb_clk.sv
tests/uart_link_chk.sv
tests/uart_link_tb.sv

//--- Makefile
# Verilator build and run for the UART link

TOOL     = verilator
FLAGS    = --binary --timing --assert
LINT     = --lint-only --timing --assert
TOP      = uart_link_tb
FLIST    = flist.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FLIST)

# The log decides pass or fail
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- tests/uart_link_tb.sv
//------------------------------
// UART link testbench: table-driven
// loopback with error injection
//------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module uart_link_tb
    import uart_pkg::*;
();

    localparam int NUM_ROWS       = 16;
    localparam int MAX_GAP        = 3;     // Idle cycles after a frame, LFSR rows
    localparam int BUSY_CYCLES    = 11;    // tx_busy length per frame
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (BUSY_CYCLES + MAX_GAP) * 2 + 20;

    localparam logic [1:0] INJ_NONE = 2'd0;
    localparam logic [1:0] INJ_PAR  = 2'd1;   // Flip parity bit
    localparam logic [1:0] INJ_STOP = 2'd2;   // Flip first stop bit

    logic       baud_clk;
    logic       reset;
    uart_byte_t data_to_tx;
    logic       start_tx;
    logic       rx;
    logic       tx;
    logic       tx_busy;
    uart_byte_t rx_data;
    logic       rx_valid;
    logic       parity_err;
    logic       frame_err;
    logic       inject;                    // Flips the loopback line

    // Stimulus and expected values, one entry per row
    uart_byte_t  byte_tab  [NUM_ROWS];
    logic [1:0]  inj_tab   [NUM_ROWS];
    int          gap_tab   [NUM_ROWS];
    logic [11:0] frame_tab [NUM_ROWS];     // Line bits, start bit at index 0
    logic        perr_tab  [NUM_ROWS];
    logic        ferr_tab  [NUM_ROWS];

    logic [15:0] lfsr      = 16'd44984;
    logic        timed_out = 1'b0;
    int          err_cnt   = 0;
    int          check_cnt = 0;
    int          valid_cnt = 0;
    int          cycle_cnt = 0;

    assign rx = tx ^ inject;               // Loopback

    uart_tb_clk #(.PERIOD_NS(8.0)) uart_tb_clk_i (.baud_clk(baud_clk));

    uart_link uart_link_i (
        .baud_clk   (baud_clk),
        .reset      (reset),
        .data_to_tx (data_to_tx),
        .start_tx   (start_tx),
        .rx         (rx),
        .tx         (tx),
        .tx_busy    (tx_busy),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .parity_err (parity_err),
        .frame_err  (frame_err)
    );

    // Galois LFSR, x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);         // One step per bit
        end
    endtask

    function automatic logic parity_of(input uart_byte_t d);
        logic p;
        p = (`UART_PARITY_ODD != 0);
        for (int i = 0; i < 8; i++) begin
            p = p ^ d[i];
        end
        return p;
    endfunction

    task automatic build_table();
        logic [7:0] b;
        byte_tab[0] = 8'h00;  inj_tab[0] = INJ_NONE;  gap_tab[0] = 0;
        byte_tab[1] = 8'hFF;  inj_tab[1] = INJ_NONE;  gap_tab[1] = 2;
        byte_tab[2] = 8'h55;  inj_tab[2] = INJ_PAR;   gap_tab[2] = 0;
        byte_tab[3] = 8'hA5;  inj_tab[3] = INJ_STOP;  gap_tab[3] = 3;
        byte_tab[4] = 8'h80;  inj_tab[4] = INJ_NONE;  gap_tab[4] = 0;
        for (int r = 5; r < NUM_ROWS; r++) begin
            take_bits(8, b);
            byte_tab[r] = b;
            take_bits(2, b);
            inj_tab[r] = (b[1:0] == 2'd3) ? INJ_NONE : b[1:0];
            take_bits(2, b);
            gap_tab[r] = int'(b[1:0]);
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            frame_tab[r] = {2'b11, parity_of(byte_tab[r]), byte_tab[r], 1'b0};
            perr_tab[r]  = (inj_tab[r] == INJ_PAR);
            ferr_tab[r]  = (inj_tab[r] == INJ_STOP);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_cnt++;
        assert (act === exp) else begin
            err_cnt++;
            $display("FAILED at %0t: %s expected %0b actual %0b", $time, name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
        check_cnt++;
        assert (act === exp) else begin
            err_cnt++;
            $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // One frame: line shape, busy length, received result
    task automatic send_row(input int r);
        data_to_tx = byte_tab[r];
        start_tx   = 1'b1;                  // Accepted at next edge, FSM idle
        for (int i = 0; i <= BUSY_CYCLES; i++) begin
            @(negedge baud_clk);
            if (i == 0) begin
                start_tx = 1'b0;
            end
            check_bit("tx", frame_tab[r][i], tx);
            check_bit("tx_busy", (i < BUSY_CYCLES), tx_busy);
            check_bit("rx_valid", (i == BUSY_CYCLES), rx_valid);
            if (i == BUSY_CYCLES) begin
                check_byte("rx_data", byte_tab[r], rx_data);
                check_bit("parity_err", perr_tab[r], parity_err);
                check_bit("frame_err", ferr_tab[r], frame_err);
            end
            inject = (inj_tab[r] == INJ_PAR && i == 9) || (inj_tab[r] == INJ_STOP && i == 10);
            if (i == 4) begin
                start_tx   = 1'b1;              // Must be ignored while busy
                data_to_tx = ~byte_tab[r];
            end
            if (i == 5) begin
                start_tx = 1'b0;
            end
        end
        repeat (gap_tab[r]) @(negedge baud_clk);
    endtask

    task finish_run();
        int total;
        total = err_cnt;
        if (timed_out) begin
            total++;
        end
        $display("Checks: %0d, errors: %0d, frames received: %0d", check_cnt, total, valid_cnt);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    always @(negedge baud_clk) begin
        if (rx_valid === 1'b1) begin
            valid_cnt++;                    // One per received frame
        end
    end

    always @(posedge baud_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            timed_out = 1'b1;
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            finish_run();
        end
    end

    initial begin
        reset      = 1'b1;
        start_tx   = 1'b0;
        data_to_tx = '0;
        inject     = 1'b0;
        build_table();
        repeat (5) @(posedge baud_clk);
        @(negedge baud_clk);
        reset = 1'b0;
        @(negedge baud_clk);
        check_bit("tx", 1'b1, tx);          // Idle after reset
        check_bit("tx_busy", 1'b0, tx_busy);
        check_bit("rx_valid", 1'b0, rx_valid);
        check_bit("parity_err", 1'b0, parity_err);
        check_bit("frame_err", 1'b0, frame_err);
        for (int r = 0; r < NUM_ROWS; r++) begin
            send_row(r);
        end
        repeat (4) @(negedge baud_clk);
        check_cnt++;
        assert (valid_cnt == NUM_ROWS) else begin
            err_cnt++;
            $display("FAILED at %0t: rx_valid pulses expected %0d actual %0d",
                     $time, NUM_ROWS, valid_cnt);
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- tests/uart_link_chk.sv
//------------------------------
// UART link protocol checks,
// bound into the link top level
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module uart_link_chk (
    input logic baud_clk,
    input logic reset,
    input logic tx,
    input logic tx_busy,
    input logic rx_valid,
    input logic parity_err,
    input logic frame_err
);

    localparam logic [4:0] BUSY_CYCLES = 5'd11;   // Start, data, parity, first stop

    logic [4:0] busy_len;                         // Cycles tx_busy has been high

    always_ff @(posedge baud_clk) begin
        if (reset || !tx_busy) begin
            busy_len <= '0;
        end else begin
            busy_len <= busy_len + 1'b1;
        end
    end

    // Line idles high between frames
    tx_idle_high: assert property (@(posedge baud_clk) disable iff (reset)
        !tx_busy |-> tx)
        else $error("tx low while transmitter idle");

    tx_start_low: assert property (@(posedge baud_clk) disable iff (reset)
        $rose(tx_busy) |-> !tx)
        else $error("frame did not open with a low start bit");

    rx_valid_pulse: assert property (@(posedge baud_clk) disable iff (reset)
        rx_valid |=> !rx_valid)
        else $error("rx_valid held for more than one cycle");

    // Flags only qualify a received byte
    err_with_valid: assert property (@(posedge baud_clk) disable iff (reset)
        (parity_err || frame_err) |-> rx_valid)
        else $error("error flag raised without rx_valid");

    busy_not_long: assert property (@(posedge baud_clk) disable iff (reset)
        tx_busy |-> (busy_len < BUSY_CYCLES))
        else $error("tx_busy high longer than one frame");

    busy_full_len: assert property (@(posedge baud_clk) disable iff (reset)
        $fell(tx_busy) |-> (busy_len == BUSY_CYCLES))
        else $error("tx_busy dropped before the frame ended");

endmodule

bind uart_link uart_link_chk uart_link_chk_i (
    .baud_clk   (baud_clk),
    .reset      (reset),
    .tx         (tx),
    .tx_busy    (tx_busy),
    .rx_valid   (rx_valid),
    .parity_err (parity_err),
    .frame_err  (frame_err)
);

`default_nettype wire

//--- tests/uart_tb_clk.sv
//------------------------------
// Testbench clock source for
// the bit-rate clock
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module uart_tb_clk #(
    parameter real PERIOD_NS = 8.0       // One bit time
) (
    output logic baud_clk
);

    initial begin
        baud_clk = 1'b0;                 // Low at time zero
        forever #(PERIOD_NS / 2.0) baud_clk = ~baud_clk;
    end

endmodule

`default_nettype wire

//--- design/uart_link.sv
//------------------------------
// UART link top: control block with
// transmit and receive datapaths
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module uart_link
    import uart_pkg::*;
(
    input  logic       baud_clk,     // Bit-rate clock
    input  logic       reset,        // Sync, active high
    input  uart_byte_t data_to_tx,   // Byte to send
    input  logic       start_tx,     // Send request
    input  logic       rx,           // Serial in
    output logic       tx,           // Serial out
    output logic       tx_busy,      // Transmit in progress
    output uart_byte_t rx_data,      // Received byte
    output logic       rx_valid,     // Received byte strobe
    output logic       parity_err,   // Parity mismatch
    output logic       frame_err     // Bad stop bit
);

    logic tx_load;         // Ctrl to tx shifter
    logic tx_shift;
    logic rx_shift_bit;    // Ctrl to rx shifter
    logic rx_check_par;
    logic rx_check_stop;

    uart_ctrl uart_ctrl_i (
        .baud_clk      (baud_clk),
        .reset         (reset),
        .start_tx      (start_tx),
        .rx            (rx),
        .tx_load       (tx_load),
        .tx_shift      (tx_shift),
        .tx_busy       (tx_busy),
        .rx_shift_bit  (rx_shift_bit),
        .rx_check_par  (rx_check_par),
        .rx_check_stop (rx_check_stop)
    );

    uart_tx_shift uart_tx_shift_i (
        .baud_clk   (baud_clk),
        .reset      (reset),
        .data_to_tx (data_to_tx),
        .tx_load    (tx_load),
        .tx_shift   (tx_shift),
        .tx         (tx)
    );

    uart_rx_shift uart_rx_shift_i (
        .baud_clk      (baud_clk),
        .reset         (reset),
        .rx            (rx),
        .rx_shift_bit  (rx_shift_bit),
        .rx_check_par  (rx_check_par),
        .rx_check_stop (rx_check_stop),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .parity_err    (parity_err),
        .frame_err     (frame_err)
    );

endmodule

`default_nettype wire

//--- design/uart_rx_shift.sv
//------------------------------
// UART receive shifter: data capture,
// parity and stop checks, result regs
//------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module uart_rx_shift
    import uart_pkg::*;
(
    input  logic       baud_clk,
    input  logic       reset,
    input  logic       rx,             // Serial input
    input  logic       rx_shift_bit,   // Data bit present on rx
    input  logic       rx_check_par,   // Parity bit present on rx
    input  logic       rx_check_stop,  // Stop bit present on rx
    output uart_byte_t rx_data,        // Valid with rx_valid
    output logic       rx_valid,       // One cycle per frame
    output logic       parity_err,     // Parity mismatch, only with rx_valid
    output logic       frame_err       // Stop bit low, only with rx_valid
);

    uart_byte_t shift_reg;      // Data bits, LSB arrives first
    logic       par_calc;       // Parity of received data
    logic       par_mismatch;   // Pending until stop bit

    assign par_calc = (^shift_reg) ^ (`UART_PARITY_ODD != 0);

    // Datapath
    always_ff @(posedge baud_clk) begin
        if (rx_shift_bit) begin
            shift_reg <= {rx, shift_reg[`UART_DATA_BITS-1:1]};   // Shift in from MSB side
        end
        if (rx_check_par) begin
            par_mismatch <= rx ^ par_calc;
        end
        if (rx_check_stop) begin
            rx_data <= shift_reg;
        end
    end

    // Result strobe and flags
    always_ff @(posedge baud_clk) begin
        if (reset) begin
            rx_valid   <= 1'b0;
            parity_err <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            rx_valid   <= rx_check_stop;
            parity_err <= rx_check_stop & par_mismatch;
            frame_err  <= rx_check_stop & ~rx;           // First stop bit must be high
        end
    end

endmodule

`default_nettype wire

//--- design/uart_tx_shift.sv
//------------------------------
// UART transmit shifter: frame load,
// parity generation and tx line
//------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module uart_tx_shift
    import uart_pkg::*;
(
    input  logic       baud_clk,
    input  logic       reset,
    input  uart_byte_t data_to_tx,   // Only read on tx_load
    input  logic       tx_load,      // Load full frame
    input  logic       tx_shift,     // Next bit onto line
    output logic       tx            // Serial output, idles high
);

    // Start, data, parity, stops
    localparam int FRAME_BITS = `UART_DATA_BITS + `UART_STOP_BITS + 2;

    logic [FRAME_BITS-1:0] frame;    // Bit 0 is on the line
    logic                  par_bit;  // Parity for data_to_tx

    // XOR of data, inverted for odd parity
    assign par_bit = (^data_to_tx) ^ (`UART_PARITY_ODD != 0);

    always_ff @(posedge baud_clk) begin
        if (reset) begin
            frame <= '1;                                 // Line high
        end else if (tx_load) begin
            frame <= {{`UART_STOP_BITS{1'b1}}, par_bit, data_to_tx, 1'b0};
        end else if (tx_shift) begin
            frame <= {1'b1, frame[FRAME_BITS-1:1]};      // Ones fill behind frame
        end
    end

    assign tx = frame[0];

endmodule

`default_nettype wire

//--- design/uart_ctrl.sv
//------------------------------
// UART control: transmit and receive
// FSMs, bit counters and datapath strobes
//------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module uart_ctrl
    import uart_pkg::*;
(
    input  logic baud_clk,       // One cycle per bit
    input  logic reset,          // Sync, active high
    input  logic start_tx,       // Request to send, sampled in TX_IDLE
    input  logic rx,             // Serial input, synchronous to baud_clk
    output logic tx_load,        // Load frame into tx shifter
    output logic tx_shift,       // Advance tx shifter one bit
    output logic tx_busy,        // Frame in progress
    output logic rx_shift_bit,   // Take data bit into rx shifter
    output logic rx_check_par,   // Sample parity bit
    output logic rx_check_stop   // Sample stop bit, publish result
);

    // Shifts after load: data, parity, stops
    localparam int TX_SHIFTS = `UART_DATA_BITS + `UART_STOP_BITS + 1;
    localparam int TX_CNT_W  = $clog2(TX_SHIFTS);
    localparam int RX_CNT_W  = $clog2(`UART_DATA_BITS);

    localparam logic [TX_CNT_W-1:0] TX_LAST = TX_CNT_W'(TX_SHIFTS - 1);
    localparam logic [RX_CNT_W-1:0] RX_LAST = RX_CNT_W'(`UART_DATA_BITS - 1);

    tx_state_e           tx_state;   // Transmit FSM
    logic [TX_CNT_W-1:0] tx_cnt;     // Shifts done in TX_SEND
    rx_state_e           rx_state;   // Receive FSM
    logic [RX_CNT_W-1:0] rx_cnt;     // Data bits taken

    // Transmit strobes
    assign tx_load  = (tx_state == TX_IDLE) && start_tx;   // Accept only when idle
    assign tx_shift = (tx_state == TX_SEND);
    assign tx_busy  = (tx_state == TX_SEND);               // Start_tx ignored while high

    // Transmit FSM
    always_ff @(posedge baud_clk) begin
        if (reset) begin
            tx_state <= TX_IDLE;
            tx_cnt   <= '0;
        end else begin
            case (tx_state)
                TX_IDLE: begin
                    tx_cnt <= '0;
                    if (tx_load) begin
                        tx_state <= TX_SEND;   // Start bit on line next cycle
                    end
                end
                TX_SEND: begin
                    if (tx_cnt == TX_LAST) begin
                        tx_state <= TX_IDLE;   // Last stop bit goes out in idle
                    end else begin
                        tx_cnt <= tx_cnt + 1'b1;
                    end
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    // Receive strobes, one per state
    assign rx_shift_bit  = (rx_state == RX_DATA);
    assign rx_check_par  = (rx_state == RX_PARITY);
    assign rx_check_stop = (rx_state == RX_STOP);

    // Receive FSM
    // Line shares baud_clk, so each bit is sampled once
    always_ff @(posedge baud_clk) begin
        if (reset) begin
            rx_state <= RX_IDLE;
            rx_cnt   <= '0;
        end else begin
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    if (!rx) begin
                        rx_state <= RX_DATA;   // Low sample is the start bit
                    end
                end
                RX_DATA: begin
                    if (rx_cnt == RX_LAST) begin
                        rx_state <= RX_PARITY;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                RX_PARITY: rx_state <= RX_STOP;
                RX_STOP:   rx_state <= RX_IDLE;    // Idle sees second stop bit
                default:   rx_state <= RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/uart_pkg.sv
//------------------------------
// UART package: data type and
// FSM state encodings
//------------------------------
`default_nettype none
`include "uart_settings.svh"

package uart_pkg;

    // Payload carried on tx and rx side
    typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

    // Transmit FSM
    typedef enum logic {
        TX_IDLE,                 // Line high, waiting for start_tx
        TX_SEND                  // Frame shifting out
    } tx_state_e;

    // Receive FSM
    typedef enum logic [1:0] {
        RX_IDLE,                 // Watching for start bit
        RX_DATA,                 // Data bits, one per cycle
        RX_PARITY,               // Parity bit sample
        RX_STOP                  // First stop bit sample
    } rx_state_e;

endpackage

`default_nettype wire

//--- design/uart_settings.svh
//------------------------------
// UART settings: frame width,
// stop bits and parity sense
//------------------------------
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Data bits per frame, sent LSB first
`define UART_DATA_BITS 8

// Stop bits sent by the transmitter
// Receiver only looks at the first one
`define UART_STOP_BITS 2

// Parity sense
// 0 even: parity bit is XOR of data bits
// 1 odd: XOR inverted
`define UART_PARITY_ODD 0

`endif
